// ==== design/axi_bus_pkg.sv ====
package axi_bus_pkg;

  // AWBURST / ARBURST encoding
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10  // Read beats only
  } axi_resp_e;

  localparam int AXI_ID_BITS  = 4;
  localparam int AXI_LEN_BITS = 8;  // Beats per burst minus one

endpackage

// ==== design/mem_cmd_pkg.sv ====
package mem_cmd_pkg;

  // Single-beat command towards the memory controller
  typedef enum logic {
    MEM_RD = 1'b0,
    MEM_WR = 1'b1
  } mem_op_e;

  typedef enum logic [1:0] {
    IDLE     = 2'b00,  // Address channels may be granted
    WR_BURST = 2'b01,
    RD_BURST = 2'b10
  } split_state_e;

  // Read FIFO holds every beat that has been asked for
  localparam int RDFIFO_ABITS = 9;
  localparam int RDFIFO_DEPTH = 1 << RDFIFO_ABITS;

  localparam int WRFIFO_ABITS = 9;

endpackage

// ==== design/mem_cmd_if.sv ====
`timescale 1ns/1ps

interface mem_cmd_if
  import axi_bus_pkg::*, mem_cmd_pkg::*;
#(
  parameter int ADDRS = 32
) ();

  logic                   valid;
  mem_op_e                op;
  logic [AXI_ID_BITS-1:0] id;
  logic [ADDRS-1:0]       addr;  // Byte address of the beat
  logic                   last;
  logic                   accept;

  // Taken when valid and accept are both high
  modport source (
    output valid, op, id, addr, last,
    input  accept
  );

  modport sink (
    input  valid, op, id, addr, last,
    output accept
  );

endinterface

// ==== design/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int ABITS = 4
) (
  input  logic             clock,
  input  logic             rst_n_i,

  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,

  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o,

  output logic [ABITS:0]   level_o
);

  localparam int DEPTH = 1 << ABITS;

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [ABITS:0]   wr_ptr_q;
  logic [ABITS:0]   rd_ptr_q;
  logic [ABITS:0]   level_next;
  logic             ready_q;
  logic             push;
  logic             pop;

  assign push = valid_i && ready_q;
  assign pop  = valid_o && ready_i;

  // Extra pointer bit tells full from empty
  assign level_o = wr_ptr_q - rd_ptr_q;
  assign valid_o = (wr_ptr_q != rd_ptr_q);
  assign data_o  = mem_q[rd_ptr_q[ABITS-1:0]];  // Head shows without a read cycle
  assign ready_o = ready_q;

  assign level_next = level_o + (ABITS+1)'(push) - (ABITS+1)'(pop);

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      ready_q  <= 1'b0;  // Rises in the first cycle out of reset
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      ready_q <= (level_next != (ABITS+1)'(DEPTH));
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      mem_q[wr_ptr_q[ABITS-1:0]] <= data_i;
    end
  end

endmodule

// ==== design/axi_burst_splitter.sv ====
`timescale 1ns/1ps

module axi_burst_splitter
  import axi_bus_pkg::*, mem_cmd_pkg::*;
#(
  parameter int ADDRS = 32,
  parameter int WIDTH = 32
) (
  input  logic                    clock,
  input  logic                    rst_n_i,

  input  logic                    awvalid_i,
  output logic                    awready_o,
  input  logic [ADDRS-1:0]        awaddr_i,
  input  logic [AXI_ID_BITS-1:0]  awid_i,
  input  logic [AXI_LEN_BITS-1:0] awlen_i,
  input  axi_burst_e              awburst_i,

  input  logic                    arvalid_i,
  output logic                    arready_o,
  input  logic [ADDRS-1:0]        araddr_i,
  input  logic [AXI_ID_BITS-1:0]  arid_i,
  input  logic [AXI_LEN_BITS-1:0] arlen_i,
  input  axi_burst_e              arburst_i,

  input  logic [RDFIFO_ABITS:0]   rd_level_i,
  input  logic                    rd_beat_i,

  mem_cmd_if.source               cmd_o
);

  localparam int BYTES = WIDTH / 8;

  split_state_e            state_q;
  logic                    awready_q;
  logic                    arready_q;
  logic                    prefer_rd_q;
  logic [ADDRS-1:0]        addr_q;
  logic [AXI_ID_BITS-1:0]  id_q;
  logic [AXI_LEN_BITS-1:0] len_q;
  logic [AXI_LEN_BITS-1:0] cnt_q;  // Beats left after the current one
  axi_burst_e              burst_q;
  logic [RDFIFO_ABITS:0]   rd_out_q;

  logic                    grant_wr;
  logic                    grant_rd;
  logic                    cmd_take;
  logic                    rd_issue;
  logic                    credit_ok;
  logic [RDFIFO_ABITS+1:0] credit_used;
  logic [ADDRS-1:0]        incr_addr;
  logic [ADDRS-1:0]        wrap_mask;
  logic [ADDRS-1:0]        next_addr;

  assign grant_wr = awready_q && awvalid_i;
  assign grant_rd = arready_q && arvalid_i;

  // Beats in flight plus beats already queued must fit the read FIFO
  assign credit_used = {1'b0, rd_out_q} + {1'b0, rd_level_i};
  assign credit_ok   = credit_used < (RDFIFO_ABITS+2)'(RDFIFO_DEPTH);

  assign cmd_o.valid = (state_q == WR_BURST) || ((state_q == RD_BURST) && credit_ok);
  assign cmd_o.op    = (state_q == WR_BURST) ? MEM_WR : MEM_RD;
  assign cmd_o.id    = id_q;
  assign cmd_o.addr  = addr_q;
  assign cmd_o.last  = (cnt_q == '0);

  assign cmd_take = cmd_o.valid && cmd_o.accept;
  assign rd_issue = cmd_take && (state_q == RD_BURST);

  assign awready_o = awready_q;
  assign arready_o = arready_q;

  // WRAP window is (len+1) beats, a power of two for legal bursts
  assign incr_addr = addr_q + ADDRS'(BYTES);
  assign wrap_mask = (ADDRS'(len_q) + ADDRS'(1)) * ADDRS'(BYTES) - ADDRS'(1);

  always_comb begin
    case (burst_q)
      FIXED:   next_addr = addr_q;
      WRAP:    next_addr = (addr_q & ~wrap_mask) | (incr_addr & wrap_mask);
      default: next_addr = incr_addr;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      awready_q   <= 1'b0;
      arready_q   <= 1'b0;
      prefer_rd_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          awready_q <= 1'b0;  // Ready lasts one cycle
          arready_q <= 1'b0;
          if (grant_wr) begin
            state_q     <= WR_BURST;
            prefer_rd_q <= 1'b1;
          end else if (grant_rd) begin
            state_q     <= RD_BURST;
            prefer_rd_q <= 1'b0;
          end else if (!awready_q && !arready_q) begin
            if (awvalid_i && (!arvalid_i || !prefer_rd_q)) begin
              awready_q <= 1'b1;
            end else if (arvalid_i) begin
              arready_q <= 1'b1;
            end
          end
        end
        default: begin
          if (cmd_take && cmd_o.last) begin
            state_q <= IDLE;
          end
        end
      endcase
    end
  end

  // Burst fields, loaded at the address handshake
  always_ff @(posedge clock) begin
    if (grant_wr || grant_rd) begin
      addr_q  <= grant_wr ? awaddr_i : araddr_i;
      id_q    <= grant_wr ? awid_i : arid_i;
      len_q   <= grant_wr ? awlen_i : arlen_i;
      cnt_q   <= grant_wr ? awlen_i : arlen_i;
      burst_q <= grant_wr ? awburst_i : arburst_i;
    end else if (cmd_take) begin
      addr_q <= next_addr;
      cnt_q  <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_out_q <= '0;
    end else begin
      case ({rd_issue, rd_beat_i})
        2'b10:   rd_out_q <= rd_out_q + 1'b1;
        2'b01:   rd_out_q <= rd_out_q - 1'b1;
        default: rd_out_q <= rd_out_q;
      endcase
    end
  end

endmodule

// ==== design/mem_port_ctrl.sv ====
`timescale 1ns/1ps

module mem_port_ctrl
  import axi_bus_pkg::*, mem_cmd_pkg::*;
#(
  parameter int WIDTH = 32
) (
  input  logic                   clock,
  input  logic                   rst_n_i,

  mem_cmd_if.sink                cmd_i,

  input  logic                   wd_valid_i,
  output logic                   wd_ready_o,
  input  logic [WIDTH-1:0]       wd_data_i,
  input  logic [WIDTH/8-1:0]     wd_strb_i,

  output logic                   ram_wren_o,
  output logic                   ram_rden_o,
  output logic [AXI_ID_BITS-1:0] ram_req_id_o,
  output logic [WIDTH-1:0]       ram_addr_o,
  output logic [WIDTH/8-1:0]     ram_wrmask_o,
  output logic [WIDTH-1:0]       ram_wrdata_o,
  input  logic                   ram_accept_i,
  input  logic                   ram_valid_i,
  input  logic                   ram_error_i,
  input  logic [AXI_ID_BITS-1:0] ram_resp_id_i,
  input  logic [WIDTH-1:0]       ram_rddata_i,

  output logic                   rd_push_o,
  output logic [WIDTH-1:0]       rd_data_o,
  output logic [AXI_ID_BITS-1:0] rd_id_o,
  output logic                   rd_last_o,
  output axi_resp_e              rd_resp_o,
  output logic                   rd_beat_o,

  output logic                   bvalid_o,
  input  logic                   bready_i,
  output logic [AXI_ID_BITS-1:0] bid_o,
  output axi_resp_e              bresp_o
);

  localparam int MASKS = WIDTH / 8;

  logic                   is_wr;
  logic                   is_rd;
  logic                   tag_ready;
  logic                   tag_push;
  logic [MASKS-1:0]       strb_w;
  logic                   bvalid_q;
  logic [AXI_ID_BITS-1:0] bid_q;

  assign is_wr = cmd_i.valid && (cmd_i.op == MEM_WR);
  assign is_rd = cmd_i.valid && (cmd_i.op == MEM_RD);

  // A pending B response holds back further write beats
  assign ram_wren_o = is_wr && wd_valid_i && !bvalid_q;
  assign ram_rden_o = is_rd && tag_ready;

  assign cmd_i.accept = (ram_wren_o || ram_rden_o) && ram_accept_i;
  assign wd_ready_o   = ram_wren_o && ram_accept_i;  // Pops the data with its command

  assign strb_w       = wd_strb_i;
  assign ram_req_id_o = cmd_i.id;
  assign ram_addr_o   = WIDTH'(cmd_i.addr);
  assign ram_wrmask_o = strb_w;
  assign ram_wrdata_o = wd_data_i;

  assign tag_push = ram_rden_o && ram_accept_i;

  // Memory answers in order, so the head tag belongs to the next beat
  sync_fifo #(
    .WIDTH (1),
    .ABITS (RDFIFO_ABITS)
  ) u_tag_fifo (
    .clock   (clock),
    .rst_n_i (rst_n_i),
    .valid_i (tag_push),
    .ready_o (tag_ready),
    .data_i  (cmd_i.last),
    .valid_o (),
    .ready_i (ram_valid_i),
    .data_o  (rd_last_o),
    .level_o ()
  );

  assign rd_push_o = ram_valid_i;
  assign rd_beat_o = ram_valid_i;
  assign rd_data_o = ram_rddata_i;
  assign rd_id_o   = ram_resp_id_i;
  assign rd_resp_o = ram_error_i ? SLVERR : OKAY;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
    end else if (wd_ready_o && cmd_i.last) begin
      bvalid_q <= 1'b1;  // Burst done once its last beat is taken
    end else if (bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (wd_ready_o && cmd_i.last) begin
      bid_q <= cmd_i.id;
    end
  end

  assign bvalid_o = bvalid_q;
  assign bid_o    = bid_q;
  assign bresp_o  = OKAY;

endmodule

// ==== design/ddr3_axi_ctrl.sv ====
`timescale 1ns/1ps

module ddr3_axi_ctrl
  import axi_bus_pkg::*, mem_cmd_pkg::*;
#(
  parameter int ADDRS = 32,
  parameter int WIDTH = 32
) (
  input  logic                    clock,
  input  logic                    rst_n_i,

  input  logic                    axi_awvalid_i,
  output logic                    axi_awready_o,
  input  logic [ADDRS-1:0]        axi_awaddr_i,
  input  logic [AXI_ID_BITS-1:0]  axi_awid_i,
  input  logic [AXI_LEN_BITS-1:0] axi_awlen_i,
  input  axi_burst_e              axi_awburst_i,

  input  logic                    axi_wvalid_i,
  output logic                    axi_wready_o,
  input  logic                    axi_wlast_i,
  input  logic [WIDTH/8-1:0]      axi_wstrb_i,
  input  logic [WIDTH-1:0]        axi_wdata_i,

  output logic                    axi_bvalid_o,
  input  logic                    axi_bready_i,
  output axi_resp_e               axi_bresp_o,
  output logic [AXI_ID_BITS-1:0]  axi_bid_o,

  input  logic                    axi_arvalid_i,
  output logic                    axi_arready_o,
  input  logic [ADDRS-1:0]        axi_araddr_i,
  input  logic [AXI_ID_BITS-1:0]  axi_arid_i,
  input  logic [AXI_LEN_BITS-1:0] axi_arlen_i,
  input  axi_burst_e              axi_arburst_i,

  input  logic                    axi_rready_i,
  output logic                    axi_rvalid_o,
  output logic                    axi_rlast_o,
  output axi_resp_e               axi_rresp_o,
  output logic [AXI_ID_BITS-1:0]  axi_rid_o,
  output logic [WIDTH-1:0]        axi_rdata_o,

  output logic                    ram_wren_o,
  output logic                    ram_rden_o,
  output logic [AXI_ID_BITS-1:0]  ram_req_id_o,
  output logic [WIDTH-1:0]        ram_addr_o,
  output logic [WIDTH/8-1:0]      ram_wrmask_o,
  output logic [WIDTH-1:0]        ram_wrdata_o,
  input  logic                    ram_accept_i,
  input  logic                    ram_valid_i,
  input  logic                    ram_error_i,
  input  logic [AXI_ID_BITS-1:0]  ram_resp_id_i,
  input  logic [WIDTH-1:0]        ram_rddata_i
);

  localparam int MASKS   = WIDTH / 8;
  localparam int WD_BITS = 1 + MASKS + WIDTH;
  localparam int RD_BITS = WIDTH + AXI_ID_BITS + 3;  // Data, id, last, resp

  logic [WD_BITS-1:0]     wd_q;
  logic                   wd_valid;
  logic                   wd_ready;
  logic                   rd_push;
  logic                   rd_beat;
  logic                   rd_last;
  logic [WIDTH-1:0]       rd_data;
  logic [AXI_ID_BITS-1:0] rd_id;
  axi_resp_e              rd_resp;
  logic [RD_BITS-1:0]     rd_q;
  logic [RDFIFO_ABITS:0]  rd_level;

  mem_cmd_if #(.ADDRS(ADDRS)) cmd_bus ();

  // Write data with strobes, beat count comes from AWLEN
  sync_fifo #(
    .WIDTH (WD_BITS),
    .ABITS (WRFIFO_ABITS)
  ) u_wrdata_fifo (
    .clock   (clock),
    .rst_n_i (rst_n_i),
    .valid_i (axi_wvalid_i),
    .ready_o (axi_wready_o),
    .data_i  ({axi_wlast_i, axi_wstrb_i, axi_wdata_i}),
    .valid_o (wd_valid),
    .ready_i (wd_ready),
    .data_o  (wd_q),
    .level_o ()
  );

  axi_burst_splitter #(
    .ADDRS (ADDRS),
    .WIDTH (WIDTH)
  ) u_splitter (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .awvalid_i  (axi_awvalid_i),
    .awready_o  (axi_awready_o),
    .awaddr_i   (axi_awaddr_i),
    .awid_i     (axi_awid_i),
    .awlen_i    (axi_awlen_i),
    .awburst_i  (axi_awburst_i),
    .arvalid_i  (axi_arvalid_i),
    .arready_o  (axi_arready_o),
    .araddr_i   (axi_araddr_i),
    .arid_i     (axi_arid_i),
    .arlen_i    (axi_arlen_i),
    .arburst_i  (axi_arburst_i),
    .rd_level_i (rd_level),
    .rd_beat_i  (rd_beat),
    .cmd_o      (cmd_bus.source)
  );

  mem_port_ctrl #(
    .WIDTH (WIDTH)
  ) u_port_ctrl (
    .clock         (clock),
    .rst_n_i       (rst_n_i),
    .cmd_i         (cmd_bus.sink),
    .wd_valid_i    (wd_valid),
    .wd_ready_o    (wd_ready),
    .wd_data_i     (wd_q[WIDTH-1:0]),
    .wd_strb_i     (wd_q[WIDTH +: MASKS]),
    .ram_wren_o    (ram_wren_o),
    .ram_rden_o    (ram_rden_o),
    .ram_req_id_o  (ram_req_id_o),
    .ram_addr_o    (ram_addr_o),
    .ram_wrmask_o  (ram_wrmask_o),
    .ram_wrdata_o  (ram_wrdata_o),
    .ram_accept_i  (ram_accept_i),
    .ram_valid_i   (ram_valid_i),
    .ram_error_i   (ram_error_i),
    .ram_resp_id_i (ram_resp_id_i),
    .ram_rddata_i  (ram_rddata_i),
    .rd_push_o     (rd_push),
    .rd_data_o     (rd_data),
    .rd_id_o       (rd_id),
    .rd_last_o     (rd_last),
    .rd_resp_o     (rd_resp),
    .rd_beat_o     (rd_beat),
    .bvalid_o      (axi_bvalid_o),
    .bready_i      (axi_bready_i),
    .bid_o         (axi_bid_o),
    .bresp_o       (axi_bresp_o)
  );

  // Room is reserved by the splitter before each read goes out
  sync_fifo #(
    .WIDTH (RD_BITS),
    .ABITS (RDFIFO_ABITS)
  ) u_rddata_fifo (
    .clock   (clock),
    .rst_n_i (rst_n_i),
    .valid_i (rd_push),
    .ready_o (),
    .data_i  ({rd_data, rd_id, rd_last, rd_resp}),
    .valid_o (axi_rvalid_o),
    .ready_i (axi_rready_i),
    .data_o  (rd_q),
    .level_o (rd_level)
  );

  assign axi_rresp_o = axi_resp_e'(rd_q[1:0]);
  assign axi_rlast_o = rd_q[2];
  assign axi_rid_o   = rd_q[3 +: AXI_ID_BITS];
  assign axi_rdata_o = rd_q[RD_BITS-1 -: WIDTH];

endmodule

// ==== bench/tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model #(
  parameter int WIDTH   = 32,
  parameter int ID_BITS = 4,
  parameter int LATENCY = 4
) (
  input  logic               clock,
  input  logic               rst_n_i,
  input  logic               wren_i,
  input  logic               rden_i,
  input  logic [ID_BITS-1:0] req_id_i,
  input  logic [WIDTH-1:0]   addr_i,
  input  logic [WIDTH/8-1:0] wrmask_i,
  input  logic [WIDTH-1:0]   wrdata_i,
  input  logic [WIDTH-1:0]   err_addr_i,
  output logic               accept_o,
  output logic               valid_o,
  output logic               error_o,
  output logic [ID_BITS-1:0] resp_id_o,
  output logic [WIDTH-1:0]   rddata_o
);

  localparam int BYTES = WIDTH / 8;

  logic [WIDTH-1:0]   mem [logic [WIDTH-1:0]];  // Keyed by word address
  logic [LATENCY-1:0] vld_pipe;
  logic [LATENCY-1:0] err_pipe;
  logic [WIDTH-1:0]   data_pipe [LATENCY];
  logic [ID_BITS-1:0] id_pipe [LATENCY];
  logic               accept_q;
  integer             seed = 81571;

  function automatic logic [WIDTH-1:0] stored_word(input logic [WIDTH-1:0] addr);
    logic [WIDTH-1:0] key;
    key = addr >> 2;
    if (mem.exists(key)) begin
      return mem[key];
    end
    return ({addr[WIDTH-1:2], 2'b00} * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;  // Never written
  endfunction

  function automatic logic [WIDTH-1:0] merge_bytes(input logic [WIDTH-1:0] old_word,
                                                   input logic [WIDTH-1:0] new_word,
                                                   input logic [BYTES-1:0] mask);
    logic [WIDTH-1:0] word;
    word = old_word;
    for (int b = 0; b < BYTES; b++) begin
      if (mask[b]) begin
        word[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return word;
  endfunction

  always @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_pipe <= '0;
      err_pipe <= '0;
      accept_q <= 1'b0;
    end else begin
      accept_q <= ($random(seed) & 3) != 0;  // Stalls about one cycle in four
      vld_pipe <= {vld_pipe[LATENCY-2:0], rden_i && accept_q};
      err_pipe <= {err_pipe[LATENCY-2:0], addr_i == err_addr_i};
    end
  end

  // Fixed latency keeps the returned beats in request order
  always @(posedge clock) begin
    data_pipe[0] <= stored_word(addr_i);
    id_pipe[0]   <= req_id_i;
    for (int s = 1; s < LATENCY; s++) begin
      data_pipe[s] <= data_pipe[s-1];
      id_pipe[s]   <= id_pipe[s-1];
    end
    if (wren_i && accept_q) begin
      mem[addr_i >> 2] = merge_bytes(stored_word(addr_i), wrdata_i, wrmask_i);
    end
  end

  assign #1 accept_o  = accept_q;
  assign #1 valid_o   = vld_pipe[LATENCY-1];
  assign #1 error_o   = err_pipe[LATENCY-1];
  assign #1 resp_id_o = id_pipe[LATENCY-1];
  assign #1 rddata_o  = data_pipe[LATENCY-1];

endmodule

// ==== bench/tb_ddr3_axi_ctrl.sv ====
`timescale 1ns/1ps

module tb_ddr3_axi_ctrl
  import axi_bus_pkg::*;
();

  localparam int ADDRS       = 32;
  localparam int WIDTH       = 32;
  localparam int STRB        = WIDTH / 8;
  localparam int TIMEOUT     = 2000;
  localparam int HOLD_CYCLES = 1200;  // Long enough for 528 beats to hit the read FIFO limit
  localparam logic [ADDRS-1:0] ERR_ADDR = 32'h0000_0408;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_READ_DEFER  // AR only, beats collected by the next OP_READ
  } tb_op_e;

  typedef struct packed {
    tb_op_e                  op;
    logic [AXI_ID_BITS-1:0]  id;
    logic [ADDRS-1:0]        addr;
    logic [AXI_LEN_BITS-1:0] len;
    axi_burst_e              burst;
    logic [WIDTH-1:0]        seed;
    logic [STRB-1:0]         strb;
    axi_resp_e               resp;
  } txn_t;

  typedef struct packed {
    logic [WIDTH-1:0]       data;
    logic [AXI_ID_BITS-1:0] id;
    logic                   last;
    axi_resp_e              resp;
  } beat_t;

  logic clock;
  logic rst_n;

  logic                    axi_awvalid;
  logic                    axi_awready;
  logic [ADDRS-1:0]        axi_awaddr;
  logic [AXI_ID_BITS-1:0]  axi_awid;
  logic [AXI_LEN_BITS-1:0] axi_awlen;
  axi_burst_e              axi_awburst;
  logic                    axi_wvalid;
  logic                    axi_wready;
  logic                    axi_wlast;
  logic [STRB-1:0]         axi_wstrb;
  logic [WIDTH-1:0]        axi_wdata;
  logic                    axi_bvalid;
  logic                    axi_bready;
  axi_resp_e               axi_bresp;
  logic [AXI_ID_BITS-1:0]  axi_bid;
  logic                    axi_arvalid;
  logic                    axi_arready;
  logic [ADDRS-1:0]        axi_araddr;
  logic [AXI_ID_BITS-1:0]  axi_arid;
  logic [AXI_LEN_BITS-1:0] axi_arlen;
  axi_burst_e              axi_arburst;
  logic                    axi_rready;
  logic                    axi_rvalid;
  logic                    axi_rlast;
  axi_resp_e               axi_rresp;
  logic [AXI_ID_BITS-1:0]  axi_rid;
  logic [WIDTH-1:0]        axi_rdata;

  logic                   ram_wren;
  logic                   ram_rden;
  logic [AXI_ID_BITS-1:0] ram_req_id;
  logic [WIDTH-1:0]       ram_addr;
  logic [STRB-1:0]        ram_wrmask;
  logic [WIDTH-1:0]       ram_wrdata;
  logic                   ram_accept;
  logic                   ram_valid;
  logic                   ram_error;
  logic [AXI_ID_BITS-1:0] ram_resp_id;
  logic [WIDTH-1:0]       ram_rddata;
  logic [WIDTH-1:0]       err_addr;

  txn_t             txns[$];
  beat_t            exp_q[$];  // R beats still owed, in order
  logic [WIDTH-1:0] shadow [logic [ADDRS-1:0]];

  ddr3_axi_ctrl #(
    .ADDRS (ADDRS),
    .WIDTH (WIDTH)
  ) u_dut (
    .clock         (clock),
    .rst_n_i       (rst_n),
    .axi_awvalid_i (axi_awvalid),
    .axi_awready_o (axi_awready),
    .axi_awaddr_i  (axi_awaddr),
    .axi_awid_i    (axi_awid),
    .axi_awlen_i   (axi_awlen),
    .axi_awburst_i (axi_awburst),
    .axi_wvalid_i  (axi_wvalid),
    .axi_wready_o  (axi_wready),
    .axi_wlast_i   (axi_wlast),
    .axi_wstrb_i   (axi_wstrb),
    .axi_wdata_i   (axi_wdata),
    .axi_bvalid_o  (axi_bvalid),
    .axi_bready_i  (axi_bready),
    .axi_bresp_o   (axi_bresp),
    .axi_bid_o     (axi_bid),
    .axi_arvalid_i (axi_arvalid),
    .axi_arready_o (axi_arready),
    .axi_araddr_i  (axi_araddr),
    .axi_arid_i    (axi_arid),
    .axi_arlen_i   (axi_arlen),
    .axi_arburst_i (axi_arburst),
    .axi_rready_i  (axi_rready),
    .axi_rvalid_o  (axi_rvalid),
    .axi_rlast_o   (axi_rlast),
    .axi_rresp_o   (axi_rresp),
    .axi_rid_o     (axi_rid),
    .axi_rdata_o   (axi_rdata),
    .ram_wren_o    (ram_wren),
    .ram_rden_o    (ram_rden),
    .ram_req_id_o  (ram_req_id),
    .ram_addr_o    (ram_addr),
    .ram_wrmask_o  (ram_wrmask),
    .ram_wrdata_o  (ram_wrdata),
    .ram_accept_i  (ram_accept),
    .ram_valid_i   (ram_valid),
    .ram_error_i   (ram_error),
    .ram_resp_id_i (ram_resp_id),
    .ram_rddata_i  (ram_rddata)
  );

  tb_mem_model #(
    .WIDTH   (WIDTH),
    .ID_BITS (AXI_ID_BITS),
    .LATENCY (4)
  ) u_mem (
    .clock      (clock),
    .rst_n_i    (rst_n),
    .wren_i     (ram_wren),
    .rden_i     (ram_rden),
    .req_id_i   (ram_req_id),
    .addr_i     (ram_addr),
    .wrmask_i   (ram_wrmask),
    .wrdata_i   (ram_wrdata),
    .err_addr_i (err_addr),
    .accept_o   (ram_accept),
    .valid_o    (ram_valid),
    .error_o    (ram_error),
    .resp_id_o  (ram_resp_id),
    .rddata_o   (ram_rddata)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #5 clock = ~clock;
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_rdata(input logic [WIDTH-1:0] exp, input logic [WIDTH-1:0] act);
    if (exp !== act) begin
      fail_run($sformatf("Mismatch rdata: expected %h, actual %h", exp, act));
    end
  endtask

  task automatic check_id(input string name, input logic [AXI_ID_BITS-1:0] exp,
                          input logic [AXI_ID_BITS-1:0] act);
    if (exp !== act) begin
      fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
    if (exp !== act) begin
      fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_last(input logic exp, input logic act);
    if (exp !== act) begin
      fail_run($sformatf("Mismatch rlast: expected %h, actual %h", exp, act));
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clock);
    #1;
  endtask

  // Byte address of one beat, from the AXI burst rules
  function automatic logic [ADDRS-1:0] beat_addr(input txn_t t, input int beat);
    logic [ADDRS-1:0] window;
    logic [ADDRS-1:0] base;
    window = (ADDRS'(t.len) + 1) * STRB;
    base   = t.addr - (t.addr % window);
    case (t.burst)
      FIXED:   return t.addr;
      WRAP:    return base + ((t.addr - base + beat * STRB) % window);
      default: return t.addr + beat * STRB;
    endcase
  endfunction

  function automatic logic [WIDTH-1:0] expected_word(input logic [ADDRS-1:0] addr);
    logic [ADDRS-1:0] key;
    key = addr >> 2;
    if (shadow.exists(key)) begin
      return shadow[key];
    end
    return ({addr[ADDRS-1:2], 2'b00} * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;  // Model fill
  endfunction

  function automatic logic [WIDTH-1:0] apply_strobe(input logic [WIDTH-1:0] old_word,
                                                    input logic [WIDTH-1:0] new_word,
                                                    input logic [STRB-1:0] strb);
    logic [WIDTH-1:0] word;
    word = old_word;
    for (int b = 0; b < STRB; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return word;
  endfunction

  task automatic send_aw(input txn_t t);
    int   waited;
    logic hs;
    waited      = 0;
    hs          = 1'b0;
    axi_awaddr  = t.addr;
    axi_awid    = t.id;
    axi_awlen   = t.len;
    axi_awburst = t.burst;
    axi_awvalid = 1'b1;
    while (!hs) begin
      @(negedge clock);
      hs = axi_awready;
      step();
      waited++;
      if (!hs && waited > TIMEOUT) begin
        fail_run($sformatf("AW channel stalled, awready never rose for id %h", t.id));
      end
    end
    axi_awvalid = 1'b0;
  endtask

  task automatic send_w(input txn_t t);
    int               waited;
    logic             hs;
    logic [ADDRS-1:0] addr;
    for (int b = 0; b <= int'(t.len); b++) begin
      waited     = 0;
      hs         = 1'b0;
      addr       = beat_addr(t, b);
      axi_wdata  = t.seed + WIDTH'(b) * 32'h0011_0001;
      axi_wstrb  = t.strb;
      axi_wlast  = (b == int'(t.len));
      axi_wvalid = 1'b1;
      while (!hs) begin
        @(negedge clock);
        hs = axi_wready;
        step();
        waited++;
        if (!hs && waited > TIMEOUT) begin
          fail_run($sformatf("W channel stalled on beat %0d of id %h", b, t.id));
        end
      end
      shadow[addr >> 2] = apply_strobe(expected_word(addr), axi_wdata, t.strb);
    end
    axi_wvalid = 1'b0;
    axi_wlast  = 1'b0;
  endtask

  task automatic wait_b(input txn_t t);
    int waited;
    waited     = 0;
    axi_bready = 1'b1;
    @(negedge clock);
    while (!axi_bvalid) begin
      waited++;
      if (waited > TIMEOUT) begin
        fail_run($sformatf("B channel stalled, no response for write id %h", t.id));
      end
      @(negedge clock);
    end
    check_id("bid", t.id, axi_bid);
    check_resp("bresp", t.resp, axi_bresp);
    step();
    axi_bready = 1'b0;
    @(negedge clock);
    if (axi_bvalid) begin
      fail_run($sformatf("A second B response followed write id %h", t.id));
    end
    step();
  endtask

  // Sends AR and records the beats it must return
  task automatic send_ar(input txn_t t);
    int               waited;
    logic             hs;
    logic [ADDRS-1:0] addr;
    beat_t            beat;
    waited      = 0;
    hs          = 1'b0;
    axi_araddr  = t.addr;
    axi_arid    = t.id;
    axi_arlen   = t.len;
    axi_arburst = t.burst;
    axi_arvalid = 1'b1;
    while (!hs) begin
      @(negedge clock);
      hs = axi_arready;
      step();
      waited++;
      if (!hs && waited > TIMEOUT) begin
        fail_run($sformatf("AR channel stalled, arready never rose for id %h", t.id));
      end
    end
    axi_arvalid = 1'b0;
    for (int b = 0; b <= int'(t.len); b++) begin
      addr      = beat_addr(t, b);
      beat.data = expected_word(addr);
      beat.id   = t.id;
      beat.last = (b == int'(t.len));
      beat.resp = (addr == ERR_ADDR) ? t.resp : OKAY;
      exp_q.push_back(beat);
    end
  endtask

  task automatic collect_reads();
    int    waited;
    beat_t exp;
    waited     = 0;
    axi_rready = 1'b1;
    while (exp_q.size() > 0) begin
      @(negedge clock);
      if (axi_rvalid) begin
        exp = exp_q.pop_front();
        check_rdata(exp.data, axi_rdata);
        check_id("rid", exp.id, axi_rid);
        check_last(exp.last, axi_rlast);
        check_resp("rresp", exp.resp, axi_rresp);
        waited = 0;
      end else begin
        waited++;
        if (waited > TIMEOUT) begin
          fail_run($sformatf("R channel stalled with %0d beats missing", exp_q.size()));
        end
      end
      step();
    end
    axi_rready = 1'b0;
  endtask

  task automatic load_table();
    txns.push_back(txn_t'{OP_WRITE, 4'h1, 32'h0000_0100, 8'd7, INCR, 32'h1000_0000, 4'hF, OKAY});
    txns.push_back(txn_t'{OP_READ, 4'h2, 32'h0000_0100, 8'd7, INCR, 32'h0, 4'h0, OKAY});
    // Partial strobe over two words of the previous burst
    txns.push_back(txn_t'{OP_WRITE, 4'h3, 32'h0000_0104, 8'd1, INCR, 32'hAB00_CD00, 4'h5, OKAY});
    txns.push_back(txn_t'{OP_READ, 4'h4, 32'h0000_0100, 8'd3, INCR, 32'h0, 4'h0, OKAY});
    txns.push_back(txn_t'{OP_WRITE, 4'h5, 32'h0000_0200, 8'd3, FIXED, 32'h2000_0040, 4'hF, OKAY});
    txns.push_back(txn_t'{OP_READ, 4'h6, 32'h0000_0200, 8'd0, INCR, 32'h0, 4'h0, OKAY});
    txns.push_back(txn_t'{OP_WRITE, 4'h7, 32'h0000_0308, 8'd3, WRAP, 32'h3000_0300, 4'hF, OKAY});
    txns.push_back(txn_t'{OP_READ, 4'h8, 32'h0000_0300, 8'd3, INCR, 32'h0, 4'h0, OKAY});
    txns.push_back(txn_t'{OP_WRITE, 4'h9, 32'h0000_03E4, 8'd7, WRAP, 32'h3E00_1000, 4'hF, OKAY});
    txns.push_back(txn_t'{OP_READ, 4'hA, 32'h0000_03E8, 8'd7, WRAP, 32'h0, 4'h0, OKAY});
    txns.push_back(txn_t'{OP_READ, 4'hB, 32'h0000_030C, 8'd2, FIXED, 32'h0, 4'h0, OKAY});
    txns.push_back(txn_t'{OP_WRITE, 4'hC, 32'h0000_0400, 8'd3, INCR, 32'h4000_0000, 4'hF, OKAY});
    txns.push_back(txn_t'{OP_READ, 4'hD, 32'h0000_0400, 8'd3, INCR, 32'h0, 4'h0, SLVERR});
    // Two full bursts fill the read FIFO, the third waits for credit
    txns.push_back(txn_t'{OP_READ_DEFER, 4'hE, 32'h0000_8000, 8'd255, INCR, 32'h0, 4'h0, OKAY});
    txns.push_back(txn_t'{OP_READ_DEFER, 4'hF, 32'h0000_9000, 8'd255, INCR, 32'h0, 4'h0, OKAY});
    txns.push_back(txn_t'{OP_READ, 4'h0, 32'h0000_0100, 8'd15, INCR, 32'h0, 4'h0, OKAY});
    txns.push_back(txn_t'{OP_WRITE, 4'h2, 32'h0000_0500, 8'd15, INCR, 32'h5500_0000, 4'h8, OKAY});
    txns.push_back(txn_t'{OP_READ, 4'h3, 32'h0000_0500, 8'd15, INCR, 32'h0, 4'h0, OKAY});
  endtask

  initial begin
    rst_n       = 1'b0;
    axi_awvalid = 1'b0;
    axi_awaddr  = '0;
    axi_awid    = '0;
    axi_awlen   = '0;
    axi_awburst = INCR;
    axi_wvalid  = 1'b0;
    axi_wlast   = 1'b0;
    axi_wstrb   = '0;
    axi_wdata   = '0;
    axi_bready  = 1'b0;
    axi_arvalid = 1'b0;
    axi_araddr  = '0;
    axi_arid    = '0;
    axi_arlen   = '0;
    axi_arburst = INCR;
    axi_rready  = 1'b0;
    err_addr    = ERR_ADDR;
    load_table();

    repeat (15) @(posedge clock);
    @(negedge clock);
    if (axi_awready || axi_arready || axi_wready || axi_bvalid || axi_rvalid ||
        ram_wren || ram_rden) begin
      fail_run("A valid or ready output was high during reset");
    end
    step();
    rst_n = 1'b1;
    step();
    @(negedge clock);
    if (!axi_wready) begin
      fail_run("W channel was not ready in the first cycle after reset");
    end
    step();

    for (int i = 0; i < txns.size(); i++) begin
      case (txns[i].op)
        OP_WRITE: begin
          send_aw(txns[i]);
          send_w(txns[i]);
          wait_b(txns[i]);
        end
        OP_READ: begin
          send_ar(txns[i]);
          if (exp_q.size() > int'(txns[i].len) + 1) begin
            repeat (HOLD_CYCLES) step();  // R stays blocked while older bursts pile up
          end
          collect_reads();
        end
        default: begin
          send_ar(txns[i]);
        end
      endcase
    end

    repeat (8) step();
    @(negedge clock);
    if (axi_bvalid || axi_rvalid) begin
      fail_run("A B or R response was left over after the last transaction");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
design/axi_bus_pkg.sv
design/mem_cmd_pkg.sv
design/mem_cmd_if.sv
design/sync_fifo.sv
design/axi_burst_splitter.sv
design/mem_port_ctrl.sv
design/ddr3_axi_ctrl.sv
bench/tb_mem_model.sv
bench/tb_ddr3_axi_ctrl.sv

// ==== Bender.yml ====
package:
  name: ddr3_axi_ctrl

sources:
  - design/axi_bus_pkg.sv
  - design/mem_cmd_pkg.sv
  - design/mem_cmd_if.sv
  - design/sync_fifo.sv
  - design/axi_burst_splitter.sv
  - design/mem_port_ctrl.sv
  - design/ddr3_axi_ctrl.sv
  - target: simulation
    files:
      - bench/tb_mem_model.sv
      - bench/tb_ddr3_axi_ctrl.sv
